//--- common/noc_consts.svh
////////////////////////////////////////////////////////////
// Constants for the 4x4 mesh NoC router
//   flit kind codes carried in the top bits of each flit
//   input FIFO depth and the number of router ports
//   port indices shared by port sets, grants and links
////////////////////////////////////////////////////////////

`ifndef NOC_CONSTS_SVH
`define NOC_CONSTS_SVH

// Flit kinds, 2 bits each
`define NOC_HEADER  2'd0
`define NOC_PAYLOAD 2'd1
`define NOC_TAIL    2'd2

// Flits held by each input FIFO
`define NOC_FIFO_DEPTH 4

// Router ports
`define NOC_PORTS 5

// Port indices, matching bit positions in a port set
`define NOC_PORT_N 0
`define NOC_PORT_E 1
`define NOC_PORT_W 2
`define NOC_PORT_S 3
`define NOC_PORT_L 4

`endif

//--- common/nocPkg.sv
////////////////////////////////////////////////////////////
// Shared types for the 4x4 mesh NoC router
//   flit kind, mesh address, header body and flit body union
//   flit and link words
//   port set and routing configuration words
////////////////////////////////////////////////////////////

package nocPkg;

  // Flit kind code, see noc_consts.svh
  typedef logic [1:0] flitKindT;

  // Router address in the mesh
  // x in the low bits, y in the high bits
  typedef struct packed {
    logic [1:0] y;
    logic [1:0] x;
  } meshAddrT;

  // Header flit body, 14 bits
  typedef struct packed {
    meshAddrT   srcAddr;
    meshAddrT   dstAddr;
    logic [5:0] seq;
  } headerBodyT;

  // Same 14-bit word seen two ways
  // headers decode addresses, payload and tail flits carry data
  typedef union packed {
    headerBodyT  hdr;
    logic [13:0] data;
  } flitBodyU;

  // One flit, 16 bits
  typedef struct packed {
    flitKindT kind;
    flitBodyU body;
  } flitT;

  // One link direction, a valid strobe with its flit
  typedef struct packed {
    logic valid;
    flitT flit;
  } linkT;

  // One bit per port, n at bit 0 up to l at bit 4
  typedef struct packed {
    logic l;
    logic s;
    logic w;
    logic e;
    logic n;
  } portSetT;

  // Routing configuration, sampled by the route units in reset
  // rxy bit 0 upward: Rne Rnw Ren Res Rwn Rws Rse Rsw
  // cx bit 0 upward: Cn Ce Cw Cs
  typedef struct packed {
    meshAddrT   curAddr;
    logic [3:0] cx;
    logic [7:0] rxy;
  } routeCfgT;

endpackage

//--- hw/router/inputFifo.sv
////////////////////////////////////////////////////////////
// inputFifo
//   show-ahead circular flit buffer for one input port
//   written on the link valid strobe, popped by grant or drop
//   sticky overflow flag for writes lost to a full buffer
////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`include "noc_consts.svh"

module inputFifo (
  input  logic          clk,
  input  logic          rst,
  input  nocPkg::linkT  inLink,
  input  logic          pop,
  output nocPkg::flitT  head,
  output logic          empty,
  output logic          overflow
);

  localparam int Depth = `NOC_FIFO_DEPTH;
  localparam int PtrW  = $clog2(Depth);
  localparam int CntW  = $clog2(Depth + 1);

  nocPkg::flitT  mem [Depth];
  logic [PtrW-1:0] wrPtr;
  logic [PtrW-1:0] rdPtr;
  logic [CntW-1:0] count;
  logic            full;
  logic            doPush;
  logic            doPop;

  assign empty = (count == '0);
  assign full  = (count == CntW'(Depth));

  // A pop in the same cycle frees a slot for the incoming flit
  assign doPush = inLink.valid && (!full || pop);
  // Pop of an empty buffer is ignored
  assign doPop  = pop && !empty;

  // Show-ahead, head is valid whenever empty is low
  assign head = mem[rdPtr];

  // Storage
  always_ff @(posedge clk) begin
    if (doPush) begin
      mem[wrPtr] <= inLink.flit;
    end
  end

  // Pointers, occupancy and the sticky overflow bit
  always_ff @(posedge clk) begin
    if (rst) begin
      wrPtr    <= '0;
      rdPtr    <= '0;
      count    <= '0;
      overflow <= 1'b0;
    end else begin
      if (doPush) begin
        wrPtr <= (wrPtr == PtrW'(Depth - 1)) ? '0 : wrPtr + 1'b1;
      end
      if (doPop) begin
        rdPtr <= (rdPtr == PtrW'(Depth - 1)) ? '0 : rdPtr + 1'b1;
      end
      // occupancy only moves when exactly one side acts
      if (doPush && !doPop) begin
        count <= count + 1'b1;
      end else if (doPop && !doPush) begin
        count <= count - 1'b1;
      end
      // Flit lost, hold the flag until reset
      if (inLink.valid && !doPush) begin
        overflow <= 1'b1;
      end
    end
  end

endmodule

//--- hw/router/lbdrRoute.sv
////////////////////////////////////////////////////////////
// lbdrRoute
//   LBDR route computation for one input port
//   minimal routes only, no deroutes and no forks
//   port choice held from header until the tail is popped
//   discard pop for packets whose route set is empty
////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`include "noc_consts.svh"

module lbdrRoute (
  input  logic             clk,
  input  logic             rst,
  input  nocPkg::routeCfgT cfg,
  input  nocPkg::flitT     head,
  input  logic             empty,
  input  logic             pop,
  output nocPkg::portSetT  request,
  output logic             dropPop
);

  nocPkg::routeCfgT cfgQ;
  nocPkg::portSetT  route;
  nocPkg::portSetT  nextRoute;
  nocPkg::meshAddrT dstAddr;
  logic             held;
  logic             isHeader;
  logic             isBody;
  logic             isTail;
  logic             moveN, moveE, moveW, moveS;
  logic             goN, goE, goW, goS, goL;

  // Routing bits
  logic rne, rnw, ren, res, rwn, rws, rse, rsw;
  // Connectivity bits
  logic cn, ce, cw, cs;

  assign rne = cfgQ.rxy[0];
  assign rnw = cfgQ.rxy[1];
  assign ren = cfgQ.rxy[2];
  assign res = cfgQ.rxy[3];
  assign rwn = cfgQ.rxy[4];
  assign rws = cfgQ.rxy[5];
  assign rse = cfgQ.rxy[6];
  assign rsw = cfgQ.rxy[7];

  assign cn = cfgQ.cx[0];
  assign ce = cfgQ.cx[1];
  assign cw = cfgQ.cx[2];
  assign cs = cfgQ.cx[3];

  assign isHeader = (head.kind == `NOC_HEADER);
  assign isTail   = (head.kind == `NOC_TAIL);
  assign isBody   = (head.kind == `NOC_PAYLOAD) || isTail;

  // Destination only means something on a header flit
  assign dstAddr = head.body.hdr.dstAddr;

  // Move flags, north is toward smaller y
  assign moveN = dstAddr.y < cfgQ.curAddr.y;
  assign moveS = cfgQ.curAddr.y < dstAddr.y;
  assign moveE = cfgQ.curAddr.x < dstAddr.x;
  assign moveW = dstAddr.x < cfgQ.curAddr.x;

  // Quadrant bits pick the port for diagonal destinations
  assign goN = ((moveN & ~moveE & ~moveW) | (moveN & moveE & rne) | (moveN & moveW & rnw)) & cn;
  assign goE = ((moveE & ~moveN & ~moveS) | (moveE & moveN & ren) | (moveE & moveS & res)) & ce;
  assign goW = ((moveW & ~moveN & ~moveS) | (moveW & moveN & rwn) | (moveW & moveS & rws)) & cw;
  assign goS = ((moveS & ~moveE & ~moveW) | (moveS & moveE & rse) | (moveS & moveW & rsw)) & cs;
  // Arrived, eject locally
  assign goL = ~moveN & ~moveE & ~moveW & ~moveS;

  // Keep one port only, so a badly set Rxy cannot fork the packet
  always_comb begin
    nextRoute = '0;
    if (goN) begin
      nextRoute.n = 1'b1;
    end else if (goE) begin
      nextRoute.e = 1'b1;
    end else if (goW) begin
      nextRoute.w = 1'b1;
    end else if (goS) begin
      nextRoute.s = 1'b1;
    end else if (goL) begin
      nextRoute.l = 1'b1;
    end
  end

  // Config sampled while in reset, route held per packet
  always_ff @(posedge clk) begin
    if (rst) begin
      cfgQ  <= cfg;
      held  <= 1'b0;
      route <= '0;
    end else if (!held) begin
      if (!empty && isHeader) begin
        held  <= 1'b1;
        route <= nextRoute;
      end
    end else if (pop && !empty && isTail) begin
      // Tail leaves at this edge, next header gets a new route
      held  <= 1'b0;
      route <= '0;
    end
  end

  // No request while the FIFO is empty between gapped flits
  assign request = (held && !empty) ? route : '0;

  // Discard flits of a blocked packet, and stray body flits
  // left over from a header lost to overflow
  assign dropPop = !empty && ((held && (route == '0)) || (!held && isBody));

endmodule

//--- hw/router/outputArbiter.sv
////////////////////////////////////////////////////////////
// outputArbiter
//   round-robin grant over the inputs asking for one output
//   locked to the winner until its tail flit is granted
//   registered output link, valid one edge after the grant
////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`include "noc_consts.svh"

module outputArbiter (
  input  logic            clk,
  input  logic            rst,
  input  nocPkg::portSetT requests,
  input  nocPkg::flitT    heads [`NOC_PORTS],
  output nocPkg::portSetT grant,
  output nocPkg::linkT    outLink
);

  localparam int IdxW = $clog2(`NOC_PORTS);

  logic [`NOC_PORTS-1:0] reqVec;
  logic [`NOC_PORTS-1:0] grantVec;
  logic [IdxW-1:0]       lastWin;
  logic [IdxW-1:0]       winIdx;
  logic                  locked;
  logic                  winValid;
  logic                  outValid;
  nocPkg::flitT          outFlit;

  // Bit k is the request of input k
  assign reqVec = requests;

  // Winner selection
  always_comb begin
    int cand;
    winValid = 1'b0;
    winIdx   = '0;
    cand     = 0;
    if (locked) begin
      // mid-packet, only the last winner may continue
      winValid = reqVec[lastWin];
      winIdx   = lastWin;
    end else begin
      // Scan from farthest to nearest, so the input just after
      // the last winner ends up with the final say
      for (int off = `NOC_PORTS; off >= 1; off--) begin
        cand = (int'(lastWin) + off) % `NOC_PORTS;
        if (reqVec[cand]) begin
          winValid = 1'b1;
          winIdx   = IdxW'(cand);
        end
      end
    end
  end

  // One-hot grant, pops the winning FIFO this cycle
  always_comb begin
    grantVec = '0;
    if (winValid) begin
      grantVec[winIdx] = 1'b1;
    end
  end

  assign grant = grantVec;

  // Lock and round-robin state
  always_ff @(posedge clk) begin
    if (rst) begin
      outValid <= 1'b0;
      locked   <= 1'b0;
      // North gets first turn after reset
      lastWin  <= IdxW'(`NOC_PORTS - 1);
    end else begin
      outValid <= winValid;
      if (winValid) begin
        lastWin <= winIdx;
        // Release on the tail, stay locked otherwise
        locked  <= (heads[winIdx].kind != `NOC_TAIL);
      end
    end
  end

  // Output flit register
  always_ff @(posedge clk) begin
    if (winValid) begin
      outFlit <= heads[winIdx];
    end
  end

  assign outLink = '{valid: outValid, flit: outFlit};

endmodule

//--- hw/router/nocRouter.sv
////////////////////////////////////////////////////////////
// nocRouter
//   five-port wormhole router for a 4x4 mesh
//   per input: show-ahead FIFO and LBDR route unit
//   per output: round-robin arbiter driving the link
////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`include "noc_consts.svh"

module nocRouter (
  input  logic             clk,
  input  logic             rst,
  input  nocPkg::routeCfgT routeCfg,
  input  nocPkg::linkT     inLinks [`NOC_PORTS],
  output nocPkg::linkT     outLinks [`NOC_PORTS],
  output nocPkg::portSetT  overflow
);

  // Per input
  nocPkg::flitT          heads [`NOC_PORTS];
  nocPkg::portSetT       routeReq [`NOC_PORTS];
  logic [`NOC_PORTS-1:0] fifoEmpty;
  logic [`NOC_PORTS-1:0] fifoPop;
  logic [`NOC_PORTS-1:0] dropPop;
  logic [`NOC_PORTS-1:0] ovfBits;

  // Per output, indexed by input
  nocPkg::portSetT       arbReq [`NOC_PORTS];
  nocPkg::portSetT       arbGrant [`NOC_PORTS];

  assign overflow = ovfBits;

  for (genvar i = 0; i < `NOC_PORTS; i++) begin : gIn
    inputFifo inputFifo_inst (
      .clk      (clk),
      .rst      (rst),
      .inLink   (inLinks[i]),
      .pop      (fifoPop[i]),
      .head     (heads[i]),
      .empty    (fifoEmpty[i]),
      .overflow (ovfBits[i])
    );

    lbdrRoute lbdrRoute_inst (
      .clk     (clk),
      .rst     (rst),
      .cfg     (routeCfg),
      .head    (heads[i]),
      .empty   (fifoEmpty[i]),
      .pop     (fifoPop[i]),
      .request (routeReq[i]),
      .dropPop (dropPop[i])
    );

    // At most one output requests a given input, so one grant at most
    assign fifoPop[i] = dropPop[i]
                      | arbGrant[`NOC_PORT_N][i]
                      | arbGrant[`NOC_PORT_E][i]
                      | arbGrant[`NOC_PORT_W][i]
                      | arbGrant[`NOC_PORT_S][i]
                      | arbGrant[`NOC_PORT_L][i];
  end

  for (genvar k = 0; k < `NOC_PORTS; k++) begin : gOut
    // Output k sees bit k of every input's request
    assign arbReq[k] = '{
      n: routeReq[`NOC_PORT_N][k],
      e: routeReq[`NOC_PORT_E][k],
      w: routeReq[`NOC_PORT_W][k],
      s: routeReq[`NOC_PORT_S][k],
      l: routeReq[`NOC_PORT_L][k]
    };

    outputArbiter outputArbiter_inst (
      .clk      (clk),
      .rst      (rst),
      .requests (arbReq[k]),
      .heads    (heads),
      .grant    (arbGrant[k]),
      .outLink  (outLinks[k])
    );
  end

endmodule

//--- dv/nocRouterTb.sv
////////////////////////////////////////////////////////////
// Testbench for the nocRouter mesh router
//   clock, reset with routing config, per-cycle link driver
//   reference LBDR routing function and output compare process
//   routing, discard, contention and overflow tests
////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`include "noc_consts.svh"

module nocRouterTb;

  logic             clk;
  logic             rst;
  nocPkg::routeCfgT routeCfg;
  nocPkg::linkT     inLinks [`NOC_PORTS];
  nocPkg::linkT     outLinks [`NOC_PORTS];
  nocPkg::portSetT  overflow;

  // Expected flits, one queue per input and output pair
  nocPkg::flitT     expQ [`NOC_PORTS*`NOC_PORTS][$];
  // Input owning each output mid-packet, -1 when idle
  int               curSrc [`NOC_PORTS];
  int               checks;
  int               errors;
  int               testErrors;

  nocRouter nocRouter_inst (
    .clk      (clk),
    .rst      (rst),
    .routeCfg (routeCfg),
    .inLinks  (inLinks),
    .outLinks (outLinks),
    .overflow (overflow)
  );

  always #10 clk = ~clk;

  // Reference LBDR rule, minimal routes only
  function automatic nocPkg::portSetT expectedPort(input nocPkg::routeCfgT cfg,
                                                   input nocPkg::meshAddrT dst);
    nocPkg::portSetT ps;
    logic goNorth, goEast, goWest, goSouth;
    goNorth = dst.y < cfg.curAddr.y;
    goSouth = dst.y > cfg.curAddr.y;
    goEast  = dst.x > cfg.curAddr.x;
    goWest  = dst.x < cfg.curAddr.x;
    ps.n = cfg.cx[0] & goNorth
         & ((~goEast & ~goWest) | (goEast & cfg.rxy[0]) | (goWest & cfg.rxy[1]));
    ps.e = cfg.cx[1] & goEast
         & ((~goNorth & ~goSouth) | (goNorth & cfg.rxy[2]) | (goSouth & cfg.rxy[3]));
    ps.w = cfg.cx[2] & goWest
         & ((~goNorth & ~goSouth) | (goNorth & cfg.rxy[4]) | (goSouth & cfg.rxy[5]));
    ps.s = cfg.cx[3] & goSouth
         & ((~goEast & ~goWest) | (goEast & cfg.rxy[6]) | (goWest & cfg.rxy[7]));
    // Already there, eject locally
    ps.l = ~(goNorth | goEast | goWest | goSouth);
    return ps;
  endfunction

  // Output index of a port set, -1 when the packet is discarded
  function automatic int portIndex(input nocPkg::portSetT ps);
    logic [`NOC_PORTS-1:0] bits;
    bits = ps;
    for (int k = 0; k < `NOC_PORTS; k++) begin
      if (bits[k]) begin
        return k;
      end
    end
    return -1;
  endfunction

  // Router at x 1, y 1 so every quadrant has destinations
  function automatic nocPkg::routeCfgT makeCfg(input logic [7:0] rxy, input logic [3:0] cx);
    nocPkg::routeCfgT cfg;
    cfg.curAddr.x = 2'd1;
    cfg.curAddr.y = 2'd1;
    cfg.cx        = cx;
    cfg.rxy       = rxy;
    return cfg;
  endfunction

  // Flit idx of a packet, header first and tail last
  function automatic nocPkg::flitT packetFlit(input int idx, input int nPay, input int src,
                                              input nocPkg::meshAddrT dst, input int seq);
    nocPkg::flitT f;
    if (idx == 0) begin
      f.kind = `NOC_HEADER;
      // source field tags the input port for the checker
      f.body.hdr.srcAddr = nocPkg::meshAddrT'(4'(src));
      f.body.hdr.dstAddr = dst;
      f.body.hdr.seq     = 6'(seq);
    end else begin
      f.kind      = (idx == nPay + 1) ? `NOC_TAIL : `NOC_PAYLOAD;
      // Input index on top so a foreign flit cannot match
      f.body.data = {3'(src), 11'($urandom)};
    end
    return f;
  endfunction

  function automatic int pendingFlits();
    int total;
    total = 0;
    for (int q = 0; q < `NOC_PORTS*`NOC_PORTS; q++) begin
      total += expQ[q].size();
    end
    return total;
  endfunction

  task automatic compareFlit(input nocPkg::flitT got, input nocPkg::flitT want, input int port);
    checks++;
    if (got !== want) begin
      errors++;
      $display("MISMATCH at %0t ns: output %0d flit %h, expected %h", $time, port, got, want);
    end
  endtask

  task automatic comparePortSet(input nocPkg::portSetT got, input nocPkg::portSetT want,
                                input string what);
    checks++;
    if (got !== want) begin
      errors++;
      $display("MISMATCH at %0t ns: %s is %b, expected %b", $time, what, got, want);
    end
  endtask

  // Next drive point, all strobes low unless set again
  task automatic nextCycle();
    @(posedge clk);
    #2;
    for (int i = 0; i < `NOC_PORTS; i++) begin
      inLinks[i] = '0;
    end
  endtask

  task automatic queueFlit(input int inPort, input int outIdx, input nocPkg::flitT f);
    if (outIdx >= 0) begin
      expQ[inPort*`NOC_PORTS + outIdx].push_back(f);
    end
  endtask

  task automatic sendPacket(input int inPort, input nocPkg::meshAddrT dst, input int nPay,
                            input int seq);
    nocPkg::flitT f;
    int outIdx;
    outIdx = portIndex(expectedPort(routeCfg, dst));
    for (int k = 0; k <= nPay + 1; k++) begin
      f = packetFlit(k, nPay, inPort, dst, seq);
      queueFlit(inPort, outIdx, f);
      nextCycle();
      inLinks[inPort] = '{valid: 1'b1, flit: f};
    end
    nextCycle();
  endtask

  task automatic waitDrain(input string what);
    int cycles;
    cycles = 0;
    while (pendingFlits() != 0 && cycles < 200) begin
      @(posedge clk);
      cycles++;
    end
    if (pendingFlits() != 0) begin
      $display("TIMEOUT in %s: %0d expected flits never left the router", what, pendingFlits());
      $display("TEST RESULT: FAIL");
      $finish;
    end
    // quiet gap, a stray flit shows up here
    repeat (4) @(posedge clk);
  endtask

  // Config reaches the route units only while rst is high
  task automatic applyReset(input nocPkg::routeCfgT cfg);
    nextCycle();
    rst      = 1'b1;
    routeCfg = cfg;
    for (int q = 0; q < `NOC_PORTS*`NOC_PORTS; q++) begin
      expQ[q].delete();
    end
    for (int p = 0; p < `NOC_PORTS; p++) begin
      curSrc[p] = -1;
    end
    repeat (5) @(posedge clk);
    #2;
    rst = 1'b0;
  endtask

  task automatic endTest(input string name);
    $display("%s: %0d errors", name, errors - testErrors);
    testErrors = errors;
  endtask

  // Output checker, sampled mid-cycle when the links are stable
  always @(negedge clk) begin : compareOutputs
    nocPkg::flitT got;
    nocPkg::flitT want;
    int src;
    if (!rst) begin
      for (int p = 0; p < `NOC_PORTS; p++) begin
        if (outLinks[p].valid) begin
          got = outLinks[p].flit;
          src = curSrc[p];
          // A new packet must open with a header naming its input
          if (src < 0 && got.kind == `NOC_HEADER) begin
            src = int'(got.body.hdr.srcAddr);
          end
          if (src < 0 || src >= `NOC_PORTS || expQ[src*`NOC_PORTS + p].size() == 0) begin
            errors++;
            $display("ERROR at %0t ns: output %0d sent a flit no packet accounts for", $time, p);
          end else begin
            want = expQ[src*`NOC_PORTS + p].pop_front();
            compareFlit(got, want, p);
            curSrc[p] = (want.kind == `NOC_TAIL) ? -1 : src;
          end
        end
      end
    end
  end

  initial begin : mainSeq
    nocPkg::flitT     pkt [`NOC_PORTS][6];
    nocPkg::meshAddrT dst;
    nocPkg::portSetT  expOvf;
    logic [7:0]       rxy;
    int               nPay [`NOC_PORTS];
    int               outIdx;
    void'($urandom(91410));
    clk        = 1'b0;
    rst        = 1'b1;
    routeCfg   = '0;
    checks     = 0;
    errors     = 0;
    testErrors = 0;
    for (int i = 0; i < `NOC_PORTS; i++) begin
      inLinks[i] = '0;
      curSrc[i]  = -1;
    end

    // Test 1, Local input to all 16 nodes, XY routing
    applyReset(makeCfg(8'h3C, 4'hF));
    for (int a = 0; a < 16; a++) begin
      sendPacket(`NOC_PORT_L, nocPkg::meshAddrT'(4'(a)), 2, a);
      waitDrain("test 1");
    end
    comparePortSet(overflow, '0, "overflow");
    endTest("test 1 local to every node");

    // Test 2, YX, XY and a mixed turn set on the four diagonals
    for (int c = 0; c < 3; c++) begin
      rxy = (c == 0) ? 8'hC3 : (c == 1) ? 8'h3C : 8'h99;
      applyReset(makeCfg(rxy, 4'hF));
      for (int d = 0; d < 4; d++) begin
        dst.y = d[1] ? 2'd2 : 2'd0;
        dst.x = d[0] ? 2'd2 : 2'd0;
        sendPacket(c, dst, 1, d);
        waitDrain("test 2");
      end
    end
    comparePortSet(overflow, '0, "overflow");
    endTest("test 2 routing bits");

    // Test 3, east link cut
    applyReset(makeCfg(8'h3C, 4'hD));
    sendPacket(`NOC_PORT_L, '{y: 2'd1, x: 2'd2}, 2, 1);
    sendPacket(`NOC_PORT_L, '{y: 2'd0, x: 2'd2}, 1, 2);
    repeat (12) @(posedge clk);
    // Later packets still route
    sendPacket(`NOC_PORT_L, '{y: 2'd1, x: 2'd0}, 1, 3);
    waitDrain("test 3 west packet");
    sendPacket(`NOC_PORT_N, '{y: 2'd1, x: 2'd1}, 0, 4);
    waitDrain("test 3 local packet");
    comparePortSet(overflow, '0, "overflow");
    endTest("test 3 blocked port discard");

    // Test 4, all inputs at once toward one random output
    applyReset(makeCfg(8'h3C, 4'hF));
    for (int r = 0; r < 8; r++) begin
      dst    = nocPkg::meshAddrT'(4'($urandom_range(0, 15)));
      outIdx = portIndex(expectedPort(routeCfg, dst));
      for (int i = 0; i < `NOC_PORTS; i++) begin
        nPay[i] = $urandom_range(0, 2);
        for (int k = 0; k < nPay[i] + 2; k++) begin
          pkt[i][k] = packetFlit(k, nPay[i], i, dst, r);
          queueFlit(i, outIdx, pkt[i][k]);
        end
      end
      for (int k = 0; k < 4; k++) begin
        nextCycle();
        for (int i = 0; i < `NOC_PORTS; i++) begin
          if (k < nPay[i] + 2) begin
            inLinks[i] = '{valid: 1'b1, flit: pkt[i][k]};
          end
        end
      end
      nextCycle();
      waitDrain("test 4 contention round");
    end
    comparePortSet(overflow, '0, "overflow");
    endTest("test 4 contention");

    // Test 5, East holds Local locked while West overfills
    applyReset(makeCfg(8'h3C, 4'hF));
    dst       = routeCfg.curAddr;
    pkt[0][0] = packetFlit(0, 0, `NOC_PORT_E, dst, 1);
    queueFlit(`NOC_PORT_E, `NOC_PORT_L, pkt[0][0]);
    nextCycle();
    inLinks[`NOC_PORT_E] = '{valid: 1'b1, flit: pkt[0][0]};
    nextCycle();
    waitDrain("test 5 east header");
    // Six flits into a four deep FIFO, the last two are lost
    for (int k = 0; k < 6; k++) begin
      pkt[1][k] = packetFlit(k, 4, `NOC_PORT_W, dst, 2);
      if (k < `NOC_FIFO_DEPTH) begin
        queueFlit(`NOC_PORT_W, `NOC_PORT_L, pkt[1][k]);
      end
      nextCycle();
      inLinks[`NOC_PORT_W] = '{valid: 1'b1, flit: pkt[1][k]};
    end
    nextCycle();
    expOvf   = '0;
    expOvf.w = 1'b1;
    comparePortSet(overflow, expOvf, "overflow with west spilled");
    // East tail frees the output, West's kept flits follow
    pkt[0][1] = packetFlit(1, 0, `NOC_PORT_E, dst, 1);
    queueFlit(`NOC_PORT_E, `NOC_PORT_L, pkt[0][1]);
    nextCycle();
    inLinks[`NOC_PORT_E] = '{valid: 1'b1, flit: pkt[0][1]};
    nextCycle();
    waitDrain("test 5 release");
    comparePortSet(overflow, expOvf, "overflow after release");
    endTest("test 5 FIFO overflow");

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

//--- nocRouter.f
+incdir+common
common/nocPkg.sv
hw/router/inputFifo.sv
hw/router/lbdrRoute.sv
hw/router/outputArbiter.sv
hw/router/nocRouter.sv
dv/nocRouterTb.sv

//--- Makefile
# Verilator build and run for the nocRouter testbench
# Override any variable on the command line, e.g. make run LOG=run1.log

VERILATOR ?= verilator
TOP       ?= nocRouterTb
FILELIST  ?= nocRouter.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal

SIM_BIN = $(BUILD_DIR)/V$(TOP)
SOURCES = $(wildcard common/*.sv common/*.svh hw/router/*.sv dv/*.sv)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# The log decides the result
run: compile
	./$(SIM_BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "TEST RESULT: FAIL" $(LOG); then \
	  echo "simulation reported failure, see $(LOG)"; \
	  exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
